// File: include/spi_consts.svh
// spi host width constants

`ifndef SPI_CONSTS_SVH
`define SPI_CONSTS_SVH

// serial clock divider width
`define SPI_DIVIDER_LEN 8

// widest character in bits
`define SPI_MAX_CHAR 32

// length field holds bits minus one
`define SPI_CHAR_LEN_BITS 5

`endif

// File: src/spi_pkg.sv
// spi host types

`include "spi_consts.svh"

package spi_pkg;

  typedef logic [`SPI_DIVIDER_LEN-1:0]   divider_t;   // half period is divider + 1 clocks
  typedef logic [`SPI_CHAR_LEN_BITS-1:0] char_len_t;  // number of bits minus one
  typedef logic [`SPI_MAX_CHAR-1:0]      spi_data_t;  // tx or rx word
  typedef logic                          chan_t;      // requesting channel

  // one transfer as handed in by a channel
  typedef struct packed {
    spi_data_t data;       // transmit word, low aligned
    char_len_t len;
    divider_t  divider;
    logic      lsb_first;  // 0 sends msb first
  } spi_req_t;

  // result of one transfer
  typedef struct packed {
    spi_data_t data;  // received word, low aligned
    chan_t     chan;  // owner of the transfer
  } spi_rsp_t;

  // shift engine states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_RUN,
    ST_FINISH
  } shift_state_e;

  // arbiter states
  typedef enum logic {
    ARB_IDLE,
    ARB_WAIT_DONE
  } arb_state_e;

endpackage

// File: src/spi_clgen.sv
// spi serial clock generator

`timescale 1ns/1ps

module spi_clgen import spi_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     enable,    // high through the whole transfer
  input  logic     go,        // transfer start strobe
  input  logic     last_clk,  // final bit, no further rise
  input  divider_t divider,   // half period minus one
  output logic     sclk,
  output logic     pos_edge,  // sclk rises after this cycle
  output logic     neg_edge   // sclk falls after this cycle
);

  divider_t cnt_q;     // half period down counter
  logic     cnt_zero;  // half period expires now
  logic     cnt_one;   // expires next cycle
  logic     div_zero;  // fastest rate, toggle each cycle

  assign cnt_zero = (cnt_q == '0);
  assign cnt_one  = (cnt_q == divider_t'(1));
  assign div_zero = (divider == '0);

  // reload while disabled so the first half period is full length
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      cnt_q <= '1;
    end
    else if (!enable || cnt_zero)
    begin
      cnt_q <= divider;
    end
    else
    begin
      cnt_q <= cnt_q - divider_t'(1);
    end
  end

  // toggle on expiry, hold low once the final bit has risen
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      sclk <= 1'b0;
    end
    else if (enable && cnt_zero && (!last_clk || sclk))
    begin
      sclk <= ~sclk;
    end
  end

  // edge pulses lead the sclk change by one cycle
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      pos_edge <= 1'b0;
      neg_edge <= 1'b0;
    end
    else
    begin
      pos_edge <= (enable && !sclk && cnt_one && !last_clk)  // low half ending
                  || (div_zero && sclk && !last_clk)          // div 0, every other cycle
                  || (div_zero && go && !enable);             // div 0, first rise
      neg_edge <= (enable && sclk && cnt_one)                 // high half ending
                  || (div_zero && !sclk && enable);
    end
  end

endmodule

// File: src/spi_shift.sv
// spi shift engine

`timescale 1ns/1ps
`include "spi_consts.svh"

module spi_shift import spi_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     go,         // start strobe from arbiter
  input  spi_req_t req,        // valid with go
  input  chan_t    chan,       // owner of this request
  output logic     idle,       // ready for go
  output logic     xfer_done,  // one cycle, rsp valid
  output spi_rsp_t rsp,
  output logic     sclk,
  output logic     mosi,
  output logic     ss_n,
  input  logic     miso
);

  shift_state_e state_q;
  spi_data_t    tx_q;       // tx shift reg, next bit at the out end
  spi_data_t    rx_q;       // rx shift reg
  spi_data_t    tx_load;    // request data aligned for shifting
  spi_data_t    tx_next;    // tx reg after one shift
  char_len_t    len_q;
  char_len_t    bit_cnt_q;  // bits left after the current one
  char_len_t    align;      // rx realign for lsb first
  divider_t     div_q;
  divider_t     clk_div;    // divider seen by the clock generator
  chan_t        chan_q;
  logic         lsb_q;
  logic         last_q;     // final bit sampled
  logic         mosi_q;
  logic         ss_n_q;
  logic         running;
  logic         pos_edge;
  logic         neg_edge;

  // bit at the output end of a word
  function automatic logic out_bit(spi_data_t word, logic lsb);
    return lsb ? word[0] : word[`SPI_MAX_CHAR-1];
  endfunction

  assign running   = (state_q == ST_RUN);
  assign idle      = (state_q == ST_IDLE);
  assign xfer_done = (state_q == ST_FINISH);
  assign clk_div   = idle ? req.divider : div_q;  // new divider visible at go

  // msb first moves bit len up to the top
  assign tx_load = req.lsb_first ? req.data
                 : req.data << (char_len_t'(`SPI_MAX_CHAR - 1) - req.len);
  assign tx_next = lsb_q ? tx_q >> 1 : tx_q << 1;

  // lsb first fills from the top, shift back down
  assign align    = char_len_t'(`SPI_MAX_CHAR - 1) - len_q;
  assign rsp.data = lsb_q ? rx_q >> align : rx_q;
  assign rsp.chan = chan_q;

  assign mosi = mosi_q;
  assign ss_n = ss_n_q;

  spi_clgen u_clgen (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .enable   (running),
    .go       (go),
    .last_clk (last_q),
    .divider  (clk_div),
    .sclk     (sclk),
    .pos_edge (pos_edge),
    .neg_edge (neg_edge)
  );

  // control fsm
  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q   <= ST_IDLE;
      ss_n_q    <= 1'b1;
      mosi_q    <= 1'b0;
      last_q    <= 1'b0;
      bit_cnt_q <= '0;
    end
    else
    begin
      case (state_q)
        ST_IDLE:
        begin
          if (go)
          begin
            state_q   <= ST_RUN;
            ss_n_q    <= 1'b0;                              // select one cycle after go
            mosi_q    <= out_bit(tx_load, req.lsb_first);  // first bit before first rise
            bit_cnt_q <= req.len;
            last_q    <= 1'b0;
          end
        end
        ST_RUN:
        begin
          if (pos_edge && (bit_cnt_q == '0))
          begin
            last_q <= 1'b1;
          end
          if (neg_edge)
          begin
            if (last_q)  // final fall ends the transfer
            begin
              state_q <= ST_FINISH;
              ss_n_q  <= 1'b1;
              mosi_q  <= 1'b0;
            end
            else
            begin
              mosi_q    <= out_bit(tx_next, lsb_q);
              bit_cnt_q <= bit_cnt_q - char_len_t'(1);
            end
          end
        end
        ST_FINISH: state_q <= ST_IDLE;  // xfer_done cycle
        default:   state_q <= ST_IDLE;
      endcase
    end
  end

  // datapath
  always_ff @(posedge clk_i)
  begin
    if (idle && go)
    begin
      tx_q   <= tx_load;
      rx_q   <= '0;  // unused high bits read as zero
      len_q  <= req.len;
      div_q  <= req.divider;
      lsb_q  <= req.lsb_first;
      chan_q <= chan;
    end
    else if (running)
    begin
      if (pos_edge)  // sample on the rising edge
      begin
        rx_q <= lsb_q ? {miso, rx_q[`SPI_MAX_CHAR-1:1]} : {rx_q[`SPI_MAX_CHAR-2:0], miso};
      end
      if (neg_edge)
      begin
        tx_q <= tx_next;
      end
    end
  end

endmodule

// File: src/spi_arbiter.sv
// spi channel arbiter

`timescale 1ns/1ps

module spi_arbiter import spi_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      start0,      // channel 0 strobe
  input  spi_req_t  req0,
  input  logic      start1,      // channel 1 strobe
  input  spi_req_t  req1,
  output logic      busy0,
  output logic      busy1,
  output logic      done0,
  output logic      done1,
  output spi_data_t rx_data0,
  output spi_data_t rx_data1,
  input  logic      idle,        // engine can take go
  input  logic      xfer_done,
  input  spi_rsp_t  rsp,
  output logic      go,
  output spi_req_t  grant_req,
  output chan_t     grant_chan
);

  arb_state_e state_q;
  logic [1:0] pend_q;   // request waiting for the engine
  logic [1:0] busy_q;   // pending or on the engine
  spi_req_t   req0_q;
  spi_req_t   req1_q;
  spi_data_t  rx0_q;    // last result per channel
  spi_data_t  rx1_q;
  chan_t      last_q;   // winner of the last contended grant
  chan_t      winner;
  logic       accept0;
  logic       accept1;

  assign accept0 = start0 && !busy_q[0];  // start while busy is dropped
  assign accept1 = start1 && !busy_q[1];

  // alternate only when both wait
  assign winner = (pend_q == 2'b11) ? ~last_q : pend_q[1];

  assign go         = (state_q == ARB_IDLE) && idle && (pend_q != 2'b00);
  assign grant_chan = winner;
  assign grant_req  = winner ? req1_q : req0_q;

  // done goes to the owner named in the response
  assign done0    = (state_q == ARB_WAIT_DONE) && xfer_done && (rsp.chan == 1'b0);
  assign done1    = (state_q == ARB_WAIT_DONE) && xfer_done && (rsp.chan == 1'b1);
  assign rx_data0 = done0 ? rsp.data : rx0_q;
  assign rx_data1 = done1 ? rsp.data : rx1_q;
  assign busy0    = busy_q[0];
  assign busy1    = busy_q[1];

  always_ff @(posedge clk_i or negedge rst_ni)
  begin
    if (!rst_ni)
    begin
      state_q <= ARB_IDLE;
      pend_q  <= 2'b00;
      busy_q  <= 2'b00;
      last_q  <= 1'b1;  // channel 0 wins first contention
    end
    else
    begin
      if (accept0)
      begin
        pend_q[0] <= 1'b1;
        busy_q[0] <= 1'b1;
      end
      if (accept1)
      begin
        pend_q[1] <= 1'b1;
        busy_q[1] <= 1'b1;
      end
      if (done0)
      begin
        busy_q[0] <= 1'b0;  // low the cycle after done
      end
      if (done1)
      begin
        busy_q[1] <= 1'b0;
      end
      case (state_q)
        ARB_IDLE:
        begin
          if (go)
          begin
            state_q        <= ARB_WAIT_DONE;
            pend_q[winner] <= 1'b0;
            if (pend_q == 2'b11)
            begin
              last_q <= winner;
            end
          end
        end
        ARB_WAIT_DONE:
        begin
          if (xfer_done)
          begin
            state_q <= ARB_IDLE;  // next go one cycle after done
          end
        end
        default: state_q <= ARB_IDLE;
      endcase
    end
  end

  // request and result payload
  always_ff @(posedge clk_i)
  begin
    if (accept0)
    begin
      req0_q <= req0;
    end
    if (accept1)
    begin
      req1_q <= req1;
    end
    if (done0)
    begin
      rx0_q <= rsp.data;
    end
    if (done1)
    begin
      rx1_q <= rsp.data;
    end
  end

endmodule

// File: src/spi_host_top.sv
// spi host top level

`timescale 1ns/1ps

module spi_host_top import spi_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  // channel 0
  input  logic      start0,
  input  spi_req_t  req0,
  output logic      busy0,
  output logic      done0,
  output spi_data_t rx_data0,
  // channel 1
  input  logic      start1,
  input  spi_req_t  req1,
  output logic      busy1,
  output logic      done1,
  output spi_data_t rx_data1,
  // serial port
  output logic      sclk,
  output logic      mosi,
  output logic      ss_n,
  input  logic      miso
);

  logic     idle;        // engine free
  logic     xfer_done;   // engine finished
  logic     go;          // arbiter grant strobe
  spi_rsp_t rsp;
  spi_req_t grant_req;
  chan_t    grant_chan;

  spi_arbiter u_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .start0     (start0),
    .req0       (req0),
    .start1     (start1),
    .req1       (req1),
    .busy0      (busy0),
    .busy1      (busy1),
    .done0      (done0),
    .done1      (done1),
    .rx_data0   (rx_data0),
    .rx_data1   (rx_data1),
    .idle       (idle),
    .xfer_done  (xfer_done),
    .rsp        (rsp),
    .go         (go),
    .grant_req  (grant_req),
    .grant_chan (grant_chan)
  );

  spi_shift u_shift (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .go        (go),
    .req       (grant_req),
    .chan      (grant_chan),
    .idle      (idle),
    .xfer_done (xfer_done),
    .rsp       (rsp),
    .sclk      (sclk),
    .mosi      (mosi),
    .ss_n      (ss_n),
    .miso      (miso)
  );

endmodule

// File: testbench/tb_clk_gen.sv
// testbench clock and reset

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk_i,
  output logic rst_ni
);

  initial
  begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;  // 8 ns period
  end

  initial
  begin
    rst_ni = 1'b0;
    repeat (5) @(posedge clk_i);  // 5 cycles in reset
    #1 rst_ni = 1'b1;             // release clear of the edge
  end

endmodule

// File: testbench/spi_host_sva.sv
// spi host protocol assertions

`timescale 1ns/1ps

module spi_host_sva import spi_pkg::*; (
  input logic         clk_i,
  input logic         rst_ni,
  input shift_state_e state,   // engine fsm
  input logic         ss_n,
  input logic         sclk,
  input logic         go,
  input logic         idle,
  input logic         done_a,  // one cycle pulses
  input logic         done_b
);

  int unsigned fail_cnt = 0;  // watched from the testbench top

  // select tracks the run state exactly
  sel_in_run: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state == ST_RUN) == !ss_n)
    else begin $error("ss_n low outside run or high during run"); fail_cnt++; end

  // no serial clock while deselected
  sclk_quiet: assert property (@(posedge clk_i) disable iff (!rst_ni) ss_n |-> !sclk)
    else begin $error("sclk high while ss_n high"); fail_cnt++; end

  go_when_idle: assert property (@(posedge clk_i) disable iff (!rst_ni) go |-> idle)
    else begin $error("go while engine not idle"); fail_cnt++; end

  done_a_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni) done_a |=> !done_a)
    else begin $error("done pulse longer than one cycle"); fail_cnt++; end

  done_b_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni) done_b |=> !done_b)
    else begin $error("done pulse longer than one cycle"); fail_cnt++; end

endmodule

bind spi_shift spi_host_sva u_shift_sva (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .state  (state_q),
  .ss_n   (ss_n),
  .sclk   (sclk),
  .go     (go),
  .idle   (idle),
  .done_a (xfer_done),
  .done_b (1'b0)
);

// arbiter side sees no serial lines, tie them quiet
bind spi_arbiter spi_host_sva u_arb_sva (
  .clk_i  (clk_i),
  .rst_ni (rst_ni),
  .state  (spi_pkg::ST_IDLE),
  .ss_n   (1'b1),
  .sclk   (1'b0),
  .go     (go),
  .idle   (idle),
  .done_a (done0),
  .done_b (done1)
);

// File: testbench/tb_spi_host.sv
// spi host testbench

`timescale 1ns/1ps
`include "spi_consts.svh"

module tb_spi_host import spi_pkg::*; ();

  localparam int MAX_DIV     = 5;  // largest divider used
  localparam int XFER_MAX    = 2 * `SPI_MAX_CHAR * (MAX_DIV + 1) + 4;  // worst transfer in cycles
  localparam int N_RANDOM    = 8;  // per channel
  localparam int N_XFERS     = 1 + 4 + 3 + 2 * N_RANDOM;
  localparam int LIMIT       = 4 * N_XFERS * XFER_MAX;
  localparam int TEST_DIV[3] = '{0, 1, MAX_DIV};

  logic        clk_i;
  logic        rst_ni;
  logic        start0;
  logic        start1;
  spi_req_t    req0;
  spi_req_t    req1;
  logic        busy0;
  logic        busy1;
  logic        done0;
  logic        done1;
  spi_data_t   rx_data0;
  spi_data_t   rx_data1;
  logic        sclk;
  logic        mosi;
  logic        ss_n;
  logic        miso;
  logic [31:0] rng_state = 32'd6532;
  spi_data_t   exp_q0[$];       // expected rx per channel
  spi_data_t   exp_q1[$];
  chan_t       done_order[$];   // channel of each done in order
  int          cycles = 0;
  logic        phase_chk = 1'b0;
  divider_t    div_exp;
  char_len_t   len_exp;
  int          high_len = 0;    // cycles of current sclk high phase
  int          rise_cnt = 0;    // sclk rises in current frame
  int          frames_seen = 0;
  logic        sclk_prev = 1'b0;
  logic        ss_n_prev = 1'b1;

  tb_clk_gen u_clk_gen (
    .clk_i  (clk_i),
    .rst_ni (rst_ni)
  );

  spi_host_top u_dut (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .start0   (start0),
    .req0     (req0),
    .busy0    (busy0),
    .done0    (done0),
    .rx_data0 (rx_data0),
    .start1   (start1),
    .req1     (req1),
    .busy1    (busy1),
    .done1    (done1),
    .rx_data1 (rx_data1),
    .sclk     (sclk),
    .mosi     (mosi),
    .ss_n     (ss_n),
    .miso     (miso)
  );

  assign miso = mosi;  // loopback

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_random();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic spi_req_t make_req(input spi_data_t d, input int bits, input int div,
                                        input logic lsb);
    spi_req_t r;
    r.data      = d;
    r.len       = char_len_t'(bits - 1);  // coded as bits minus one
    r.divider   = divider_t'(div);
    r.lsb_first = lsb;
    return r;
  endfunction

  function automatic spi_req_t random_req();
    logic [31:0] v;
    v = next_random();
    return make_req(next_random(), int'(v[4:0]) + 1, int'(v[9:8]), v[16]);  // short dividers
  endfunction

  // loopback returns the low len + 1 bits in either bit order
  function automatic spi_data_t expected_rx(input spi_req_t r);
    spi_data_t mask;
    mask = '0;
    for (int i = 0; i < `SPI_MAX_CHAR; i++)
      mask[i] = (i <= int'(r.len));
    return r.data & mask;
  endfunction

  task automatic stop_on_error();
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic report_failure(input string why);
    $display("%s, at %0t", why, $time);
    stop_on_error();
  endtask

  task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] got);
    $display("ERROR at %0t: %s expected 'h%0h, got 'h%0h", $time, name, exp, got);
    stop_on_error();
  endtask

  // called 1 ns after an edge and returns 1 ns after the next
  task automatic start_xfer(input chan_t ch, input spi_req_t r);
    if (ch)
    begin
      start1 = 1'b1;
      req1   = r;
      exp_q1.push_back(expected_rx(r));
    end
    else
    begin
      start0 = 1'b1;
      req0   = r;
      exp_q0.push_back(expected_rx(r));
    end
    @(posedge clk_i);
    #1;
    if (ch)
      start1 = 1'b0;
    else
      start0 = 1'b0;
    assert ((ch ? busy1 : busy0) === 1'b1)  // busy from the cycle after start
      else value_error(ch ? "busy1" : "busy0", 32'd1, 32'(ch ? busy1 : busy0));
  endtask

  task automatic wait_idle(input logic [1:0] chans);
    while ((chans[0] && busy0) || (chans[1] && busy1))
    begin
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic run_random(input chan_t ch, input int n);
    repeat (n)
    begin
      start_xfer(ch, random_req());
      wait_idle(ch ? 2'b10 : 2'b01);
    end
  endtask

  task automatic check_quiet();
    assert (ss_n === 1'b1) else value_error("ss_n", 32'd1, 32'(ss_n));
    assert (sclk === 1'b0) else value_error("sclk", 32'd0, 32'(sclk));
    assert (mosi === 1'b0) else value_error("mosi", 32'd0, 32'(mosi));
  endtask

  task automatic check_done(input chan_t ch, input spi_data_t got);
    spi_data_t exp;
    assert ((ch ? exp_q1.size() : exp_q0.size()) > 0)
      else report_failure("done pulse without a preceding start");
    if (ch)
      exp = exp_q1.pop_front();
    else
      exp = exp_q0.pop_front();
    done_order.push_back(ch);
    assert (got === exp) else value_error(ch ? "rx_data1" : "rx_data0", exp, got);
    assert ((ch ? busy1 : busy0) === 1'b1)  // still busy in the done cycle
      else value_error(ch ? "busy1" : "busy0", 32'd1, 32'(ch ? busy1 : busy0));
  endtask

  // compare mid cycle
  always @(negedge clk_i)
  begin
    if (rst_ni && done0)
      check_done(1'b0, rx_data0);
    if (rst_ni && done1)
      check_done(1'b1, rx_data1);
  end

  // sclk high phase and rise count per frame
  always @(negedge clk_i)
  begin
    if (phase_chk && sclk)
      high_len = high_len + 1;
    if (phase_chk && !sclk && sclk_prev)
    begin
      assert (high_len == int'(div_exp) + 1)
        else value_error("sclk high cycles", int'(div_exp) + 1, high_len);
      high_len = 0;
    end
    if (phase_chk && !ss_n && sclk && !sclk_prev)
      rise_cnt = rise_cnt + 1;
    if (phase_chk && ss_n && !ss_n_prev)  // frame ends
    begin
      assert (rise_cnt == int'(len_exp) + 1)
        else value_error("sclk rises per frame", int'(len_exp) + 1, rise_cnt);
      rise_cnt    = 0;
      frames_seen = frames_seen + 1;
    end
    sclk_prev = sclk;
    ss_n_prev = ss_n;
  end

  always @(negedge clk_i)
  begin
    assert (u_dut.u_shift.u_shift_sva.fail_cnt == 0 && u_dut.u_arbiter.u_arb_sva.fail_cnt == 0)
      else report_failure("a bound protocol assertion failed");
  end

  always @(posedge clk_i)
  begin
    cycles <= cycles + 1;
    assert (cycles < LIMIT) else report_failure("timeout, transfers did not complete in time");
  end

  initial
  begin
    int base;
    start0 = 1'b0;
    start1 = 1'b0;
    req0   = '0;
    req1   = '0;
    @(posedge rst_ni);
    @(posedge clk_i);
    #1;
    repeat (10)  // quiet lines after reset
    begin
      check_quiet();
      @(posedge clk_i);
      #1;
    end

    // one msb first byte with busy held through done
    start_xfer(1'b0, make_req(32'h1234_56a5, 8, 3, 1'b0));
    while (!done0)
    begin
      assert (busy0) else value_error("busy0", 32'd1, 32'(busy0));
      @(posedge clk_i);
      #1;
    end
    assert (busy0) else value_error("busy0", 32'd1, 32'(busy0));
    @(posedge clk_i);
    #1;
    assert (!busy0) else value_error("busy0", 32'd0, 32'(busy0));
    check_quiet();

    // same cycle starts where the winner alternates
    for (int pair = 0; pair < 2; pair++)
    begin
      base = done_order.size();
      fork
        start_xfer(1'b0, random_req());
        start_xfer(1'b1, random_req());
      join
      wait_idle(2'b11);
      assert (done_order.size() == base + 2) else report_failure("contended pair incomplete");
      assert (done_order[base] == chan_t'(pair))
        else value_error("first done channel", 32'(pair), 32'(done_order[base]));
      check_quiet();
    end

    // serial clock shape for several dividers
    phase_chk = 1'b1;
    for (int i = 0; i < 3; i++)
    begin
      div_exp = divider_t'(TEST_DIV[i]);
      len_exp = char_len_t'(9 + i);
      start_xfer(1'b0, make_req(next_random(), 10 + i, TEST_DIV[i], i[0]));
      wait_idle(2'b01);
      check_quiet();
    end
    phase_chk = 1'b0;
    assert (frames_seen == 3) else value_error("serial frames", 32'd3, frames_seen);

    fork  // random traffic on both channels
      run_random(1'b0, N_RANDOM);
      run_random(1'b1, N_RANDOM);
    join
    wait_idle(2'b11);
    check_quiet();

    assert (exp_q0.size() == 0 && exp_q1.size() == 0)
      else report_failure("transfers ended without a done pulse");
    $display("** PASS **");
    $finish;
  end

endmodule

// File: src.f
+incdir+include
src/spi_pkg.sv
src/spi_clgen.sv
src/spi_shift.sv
src/spi_arbiter.sv
src/spi_host_top.sv
testbench/tb_clk_gen.sv
testbench/spi_host_sva.sv
testbench/tb_spi_host.sv

// File: Makefile
# tool, flags, top module and file list
VERILATOR  := verilator
TOP        := tb_spi_host
FILELIST   := src.f
FLAGS      := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing --assert
SIM_ARGS   := +verilator+error+limit+100
OBJ_DIR    := obj_dir
LOG        := sim.log
FAIL_MSG   := ** FAIL **

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# a crash or nonzero exit counts as a failure too
sim: build
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || echo "$(FAIL_MSG)" >> $(LOG)
	@cat $(LOG)
	@if grep -qF '$(FAIL_MSG)' $(LOG); then echo "simulation failed"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
